// ==== all.f ====
+incdir+src
src/sdram_pkg.sv
src/sdram_bus_if.sv
src/write_fifo.sv
src/refresh_timer.sv
src/sdram_write.sv
src/sdram_pin_stage.sv
src/sdram_write_top.sv
tests/tb_clock_gen.sv
tests/sdram_write_chk.sv
tests/sdram_write_tb.sv

// ==== tests/sdram_write_tb.sv ====
`timescale 1ns/1ps
`include "sdram_macros.svh"

module sdram_write_tb;

	logic clk, rst, host_wr, host_full, en, finished;
	logic cs_n, ras_n, cas_n, we_n;
	logic [35:0] host_wdata;
	logic [21:0] write_address;
	logic [11:0] sd_addr;
	logic [1:0]  sd_bank, sd_dqm;
	logic [15:0] sd_dq;

	logic [35:0] sb[$];
	logic [35:0] cur_word;
	logic        bottom_pending = 1'b0;
	logic        disabled = 1'b1;
	logic        ar_window = 1'b0;
	logic [1:0]  exp_bank;
	logic [11:0] exp_row;
	logic [7:0]  exp_col;
	int          errors = 0;
	int          act_count = 0;
	int          pre_count = 0;
	int          ar_count = 0;
	int          cyc = 0;
	int          last_ar = 0;
	int          t, n, snap_act, snap_pre, snap_ar;
	sdram_pkg::sdram_cmd_e cmd;

	tb_clock_gen i_clk (.clk(clk), .rst(rst));

	sdram_write_top i_dut (.*);

	bind sdram_write_top sdram_write_chk i_chk (
		.clk(clk), .rst(rst), .cs_n(cs_n), .ras_n(ras_n), .cas_n(cas_n),
		.we_n(we_n), .finished(finished), .host_full(host_full)
	);

	// deselect counts as NOP
	function automatic sdram_pkg::sdram_cmd_e decode_pins(input logic [3:0] p);
		case (p)
			4'b0011: return sdram_pkg::ACT;
			4'b0100: return sdram_pkg::WRITE;
			4'b0010: return sdram_pkg::PRE;
			4'b0001: return sdram_pkg::AR;
			default: return sdram_pkg::NOP;
		endcase
	endfunction

	function automatic logic [35:0] rand_word();
		logic [63:0] r;
		r = {$urandom(), $urandom()};
		return r[35:0];
	endfunction

	task automatic check_val(input string name, input logic [35:0] got, input logic [35:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic report(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	// pin monitor, sampled mid-cycle where the registered pins are stable
	always @(negedge clk) begin
		cyc++;
		if (!rst) begin
			cmd = decode_pins({cs_n, ras_n, cas_n, we_n});
			if (bottom_pending) begin
				check_val("sd_dq bottom", sd_dq, cur_word[15:0]);
				check_val("sd_dqm bottom", sd_dqm, cur_word[33:32]);
				bottom_pending = 1'b0;
			end
			if (disabled && cmd != sdram_pkg::NOP && cmd != sdram_pkg::AR)
				report("row command on the pins after the engine finished");
			case (cmd)
				sdram_pkg::ACT: begin
					act_count++;
					check_val("sd_addr act row", sd_addr, exp_row);
					check_val("sd_bank act", sd_bank, exp_bank);
				end
				sdram_pkg::WRITE: begin
					if (sb.size() == 0) begin
						report("WRITE issued with no word pushed");
					end else begin
						cur_word = sb.pop_front();
						check_val("sd_addr write col", sd_addr, {4'h0, exp_col});
						check_val("sd_bank write", sd_bank, exp_bank);
						check_val("sd_dq top", sd_dq, cur_word[31:16]);
						check_val("sd_dqm top", sd_dqm, cur_word[35:34]);
						bottom_pending = 1'b1;
						exp_col = exp_col + 8'd2;
						if (exp_col == 8'd0)
							exp_row = exp_row + 12'd1;
					end
				end
				sdram_pkg::PRE: pre_count++;
				sdram_pkg::AR: begin
					ar_count++;
					if (ar_window) begin
						assert ((cyc - last_ar) <= `REFRESH_INTERVAL + 40)
							else report("AUTO REFRESH gap too long");
					end
					last_ar = cyc;
				end
				default: ;
			endcase
		end
	end

	task automatic push_word(input logic [35:0] w);
		int k;
		k = 0;
		while (host_full && k < 500) begin
			@(negedge clk);
			k++;
		end
		if (host_full) begin
			report("timeout waiting for room in the write FIFO");
		end else begin
			host_wdata = w;
			host_wr = 1'b1;
			sb.push_back(w);
			@(negedge clk);
			host_wr = 1'b0;
		end
	endtask

	task automatic set_target(input logic [1:0] b, input logic [11:0] r, input logic [7:0] c);
		write_address = {b, r, c};
		exp_bank = b;
		exp_row = r;
		exp_col = c;
	endtask

	task automatic wait_drained();
		int k;
		k = 0;
		while ((sb.size() != 0 || bottom_pending) && k < 2000) begin
			@(negedge clk);
			k++;
		end
		if (sb.size() != 0) report("timeout waiting for pushed words on the pins");
	endtask

	task automatic disable_engine();
		int k;
		k = 0;
		en = 1'b0;
		while (!finished && k < 200) begin
			@(negedge clk);
			k++;
		end
		if (!finished) report("timeout waiting for finished");
		disabled = 1'b1;
	endtask

	task automatic enable_engine();
		disabled = 1'b0;
		en = 1'b1;
	endtask

	initial begin
		void'($urandom(32'hd0f007be));
		host_wdata = '0;
		host_wr = 1'b0;
		en = 1'b0;
		write_address = '0;
		t = 0;
		do begin
			@(negedge clk);
			check_val("cs_n in reset", cs_n, 1);
			check_val("finished in reset", finished, 0);
			check_val("host_full in reset", host_full, 0);
			t++;
			// rst changes on the falling edge
			@(posedge clk);
		end while (rst && t < 100);
		if (rst) report("timeout waiting for reset release");
		repeat (3) begin
			@(negedge clk);
			check_val("pin command after reset", decode_pins({cs_n, ras_n, cas_n, we_n}), 0);
		end

		// bursts and data order
		set_target(2'd1, 12'h123, 8'h10);
		enable_engine();
		repeat (6) begin
			push_word(rand_word());
			repeat ($urandom % 3) @(negedge clk);
		end
		wait_drained();
		disable_engine();

		// column wrap into the next row
		set_target(2'd2, 12'h0ab, 8'hfc);
		snap_act = act_count;
		snap_pre = pre_count;
		enable_engine();
		repeat (4) push_word(rand_word());
		wait_drained();
		assert (act_count - snap_act >= 2)
			else report("no ACT on the next row after the column wrap");
		assert (pre_count - snap_pre >= 1)
			else report("no PRE at the column wrap");
		disable_engine();

		// refresh under random traffic
		set_target(2'd3, 12'h200, 8'h00);
		enable_engine();
		snap_ar = ar_count;
		last_ar = cyc;
		ar_window = 1'b1;
		repeat (600) begin
			if (($urandom % 4) == 0 && !host_full) begin
				push_word(rand_word());
			end else begin
				@(negedge clk);
			end
		end
		assert ((cyc - last_ar) <= `REFRESH_INTERVAL + 40)
			else report("no AUTO REFRESH near the end of the refresh window");
		ar_window = 1'b0;
		assert (ar_count - snap_ar >= 2)
			else report("too few AUTO REFRESH commands in the refresh window");
		wait_drained();
		disable_engine();

		// FIFO runs dry, then disable
		set_target(2'd0, 12'h055, 8'h80);
		snap_pre = pre_count;
		enable_engine();
		repeat (3) push_word(rand_word());
		wait_drained();
		t = 0;
		while (pre_count == snap_pre && t < 100) begin
			@(negedge clk);
			t++;
		end
		if (pre_count == snap_pre) report("timeout waiting for PRE after the FIFO ran dry");
		repeat (30) @(negedge clk);
		push_word(rand_word());
		wait_drained();
		en = 1'b0;
		n = 0;
		repeat (60) begin
			@(negedge clk);
			if (finished) begin
				n++;
				disabled = 1'b1;
			end
		end
		check_val("finished pulses", n, 1);

		// fill with the engine off, one extra push must be dropped
		for (int i = 0; i < `FIFO_DEPTH; i++) begin
			check_val("host_full before fill", host_full, 0);
			push_word(rand_word());
		end
		check_val("host_full after fill", host_full, 1);
		host_wdata = rand_word();
		host_wr = 1'b1;
		@(negedge clk);
		host_wr = 1'b0;
		set_target(2'd1, 12'h7fe, 8'h40);
		enable_engine();
		wait_drained();
		repeat (20) @(negedge clk);
		disable_engine();

		$display("errors: %0d testbench, %0d assertion", errors, i_dut.i_chk.fail_count);
		if (errors + i_dut.i_chk.fail_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== tests/sdram_write_chk.sv ====
`timescale 1ns/1ps
`include "sdram_macros.svh"

// protocol checks on the SDRAM pins of sdram_write_top
module sdram_write_chk (
	input logic        clk,
	input logic        rst,
	input logic        cs_n,
	input logic        ras_n,
	input logic        cas_n,
	input logic        we_n,
	input logic        finished,
	input logic        host_full
);

	int         fail_count = 0;
	logic       is_act;
	logic       is_wr;
	logic       is_pre;
	logic       is_ar;
	logic       row_open;
	// cycles since the last command of each kind, saturating
	logic [7:0] since_act;
	logic [7:0] since_pre;
	logic [7:0] since_ar;

	assign is_act = ({cs_n, ras_n, cas_n, we_n} == 4'b0011);
	assign is_wr  = ({cs_n, ras_n, cas_n, we_n} == 4'b0100);
	assign is_pre = ({cs_n, ras_n, cas_n, we_n} == 4'b0010);
	assign is_ar  = ({cs_n, ras_n, cas_n, we_n} == 4'b0001);

	function automatic logic [7:0] sat_inc(input logic [7:0] v);
		return (v == 8'hff) ? v : v + 8'd1;
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			row_open  <= 1'b0;
			since_act <= 8'hff;
			since_pre <= 8'hff;
			since_ar  <= 8'hff;
		end else begin
			since_act <= is_act ? 8'd1 : sat_inc(since_act);
			since_pre <= is_pre ? 8'd1 : sat_inc(since_pre);
			since_ar  <= is_ar ? 8'd1 : sat_inc(since_ar);
			if (is_act) begin
				row_open <= 1'b1;
			end else if (is_pre) begin
				row_open <= 1'b0;
			end
		end
	end

	a_reset: assert property (@(posedge clk) rst |=> (cs_n && !finished && !host_full))
		else begin fail_count++; $error("pins or status not idle after reset"); end
	a_rcd: assert property (@(posedge clk) disable iff (rst)
		is_wr |-> (row_open && since_act > `T_RCD))
		else begin fail_count++; $error("WRITE without open row or too soon after ACT"); end
	a_rp: assert property (@(posedge clk) disable iff (rst)
		is_act |-> (!row_open && since_pre > `T_RP))
		else begin fail_count++; $error("ACT on open row or too soon after PRE"); end
	a_rfc: assert property (@(posedge clk) disable iff (rst)
		(is_act || is_wr || is_pre || is_ar) |-> since_ar > `T_RFC)
		else begin fail_count++; $error("command too soon after AUTO REFRESH"); end
	a_ar_closed: assert property (@(posedge clk) disable iff (rst) is_ar |-> !row_open)
		else begin fail_count++; $error("AUTO REFRESH while a row is open"); end
	a_fin_pulse: assert property (@(posedge clk) disable iff (rst) finished |=> !finished)
		else begin fail_count++; $error("finished held longer than one cycle"); end

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

// 20 ns clock, reset held for 16 rising edges
module tb_clock_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// released on a falling edge like every other DUT input
	initial begin
		rst = 1'b1;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

// ==== src/sdram_write_top.sv ====
`timescale 1ns/1ps

module sdram_write_top (
	input  logic        clk,
	input  logic        rst,
	input  logic [35:0] host_wdata,
	input  logic        host_wr,
	output logic        host_full,
	input  logic        en,
	input  logic [21:0] write_address,
	output logic        finished,
	output logic        cs_n,
	output logic        ras_n,
	output logic        cas_n,
	output logic        we_n,
	output logic [11:0] sd_addr,
	output logic [1:0]  sd_bank,
	output logic [15:0] sd_dq,
	output logic [1:0]  sd_dqm
);

	logic [35:0] fifo_data;
	logic        fifo_empty;
	logic        fifo_rd;
	logic        auto_rfrsh;

	sdram_bus_if bus ();

	write_fifo i_fifo (
		.clk   (clk),
		.rst   (rst),
		.wdata (host_wdata),
		.wr    (host_wr),
		.full  (host_full),
		.rdata (fifo_data),
		.rd    (fifo_rd),
		.empty (fifo_empty)
	);

	refresh_timer i_timer (
		.clk        (clk),
		.rst        (rst),
		.auto_rfrsh (auto_rfrsh)
	);

	sdram_write i_write (
		.clk           (clk),
		.rst           (rst),
		.en            (en),
		.write_address (write_address),
		.finished      (finished),
		.auto_rfrsh    (auto_rfrsh),
		.fifo_data     (fifo_data),
		.fifo_empty    (fifo_empty),
		.fifo_rd       (fifo_rd),
		.bus           (bus.ctl)
	);

	sdram_pin_stage i_pins (
		.clk     (clk),
		.rst     (rst),
		.bus     (bus.phy),
		.cs_n    (cs_n),
		.ras_n   (ras_n),
		.cas_n   (cas_n),
		.we_n    (we_n),
		.sd_addr (sd_addr),
		.sd_bank (sd_bank),
		.sd_dq   (sd_dq),
		.sd_dqm  (sd_dqm)
	);

endmodule

// ==== src/sdram_pin_stage.sv ====
`timescale 1ns/1ps

module sdram_pin_stage (
	input  logic        clk,
	input  logic        rst,
	sdram_bus_if.phy    bus,
	output logic        cs_n,
	output logic        ras_n,
	output logic        cas_n,
	output logic        we_n,
	output logic [11:0] sd_addr,
	output logic [1:0]  sd_bank,
	output logic [15:0] sd_dq,
	output logic [1:0]  sd_dqm
);

	// JEDEC encoding as cs_n ras_n cas_n we_n
	always_ff @(posedge clk) begin
		if (rst) begin
			// deselected during reset
			{cs_n, ras_n, cas_n, we_n} <= 4'b1111;
		end else begin
			case (bus.cmd)
				sdram_pkg::NOP:   {cs_n, ras_n, cas_n, we_n} <= 4'b0111;
				sdram_pkg::ACT:   {cs_n, ras_n, cas_n, we_n} <= 4'b0011;
				sdram_pkg::WRITE: {cs_n, ras_n, cas_n, we_n} <= 4'b0100;
				sdram_pkg::PRE:   {cs_n, ras_n, cas_n, we_n} <= 4'b0010;
				sdram_pkg::AR:    {cs_n, ras_n, cas_n, we_n} <= 4'b0001;
				default:          {cs_n, ras_n, cas_n, we_n} <= 4'b1111;
			endcase
		end
	end

	// address and data follow the command by the same single stage
	always_ff @(posedge clk) begin
		sd_addr <= bus.addr;
		sd_bank <= bus.bank;
		sd_dq   <= bus.dq;
		sd_dqm  <= bus.dqm;
	end

endmodule

// ==== src/sdram_write.sv ====
`timescale 1ns/1ps
`include "sdram_macros.svh"

module sdram_write (
	input  logic        clk,
	input  logic        rst,
	input  logic        en,
	input  logic [21:0] write_address,
	output logic        finished,
	input  logic        auto_rfrsh,
	input  logic [35:0] fifo_data,
	input  logic        fifo_empty,
	output logic        fifo_rd,
	sdram_bus_if.ctl    bus
);

	sdram_pkg::write_state_e state;

	// NOP cycles still owed to the SDRAM
	logic [3:0]  delay;
	// refresh request held until AR goes out
	logic        rfsh_pend;
	// write recovery already served, PRE is next
	logic        closing;
	// column counter ran past the end of the row
	logic        row_end;

	logic [1:0]  cur_bank;
	logic [11:0] cur_row;
	logic [7:0]  cur_col;
	logic [8:0]  col_step;
	logic        can_continue;
	logic        start_write;

	// two beats per word, so the column moves by two
	assign col_step = {1'b0, cur_col} + 9'd2;

	assign can_continue = en && !fifo_empty && !rfsh_pend && !row_end;

	// the first write of a row is always taken, a word is known to be there
	assign start_write = (state == sdram_pkg::WRITE_CMD) ||
		((state == sdram_pkg::WRITE_TOP) && can_continue && !closing);

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= sdram_pkg::IDLE;
			delay     <= 4'd0;
			rfsh_pend <= 1'b0;
			closing   <= 1'b0;
			row_end   <= 1'b0;
			fifo_rd   <= 1'b0;
			finished  <= 1'b0;
			bus.cmd   <= sdram_pkg::NOP;
			bus.dqm   <= 2'b11;
		end else begin
			fifo_rd  <= 1'b0;
			finished <= 1'b0;
			bus.cmd  <= sdram_pkg::NOP;
			bus.dqm  <= 2'b11;

			if (delay != 4'd0) begin
				delay <= delay - 4'd1;
			end else begin
				case (state)
					sdram_pkg::IDLE,
					sdram_pkg::FIFO_WAIT,
					sdram_pkg::RESTART: begin
						// row is closed here, so refresh goes first
						if (rfsh_pend) begin
							bus.cmd   <= sdram_pkg::AR;
							rfsh_pend <= 1'b0;
							delay     <= `T_RFC;
						end else if (state == sdram_pkg::IDLE) begin
							if (en && !fifo_empty) begin
								cur_bank <= write_address[21:20];
								cur_row  <= write_address[19:8];
								cur_col  <= write_address[7:0];
								state    <= sdram_pkg::ACTIVE;
							end
						end else if (!en) begin
							state    <= sdram_pkg::IDLE;
							finished <= 1'b1;
						end else if (fifo_empty) begin
							state <= sdram_pkg::FIFO_WAIT;
						end else begin
							state <= sdram_pkg::ACTIVE;
						end
					end
					sdram_pkg::ACTIVE: begin
						bus.cmd  <= sdram_pkg::ACT;
						bus.addr <= cur_row;
						bus.bank <= cur_bank;
						row_end  <= 1'b0;
						delay    <= `T_RCD;
						state    <= sdram_pkg::WRITE_CMD;
					end
					sdram_pkg::WRITE_CMD,
					sdram_pkg::WRITE_TOP: begin
						if (start_write) begin
							// top beat goes out with the command
							bus.cmd  <= sdram_pkg::WRITE;
							bus.addr <= {4'h0, cur_col};
							bus.bank <= cur_bank;
							bus.dq   <= fifo_data[31:16];
							bus.dqm  <= fifo_data[35:34];
							fifo_rd  <= 1'b1;
							closing  <= 1'b0;
							cur_col  <= col_step[7:0];
							if (col_step[8]) begin
								row_end <= 1'b1;
								cur_row <= cur_row + 12'd1;
							end
							state <= sdram_pkg::WRITE_BOTTOM;
						end else if (!closing) begin
							closing <= 1'b1;
							delay   <= `T_CAS;
						end else begin
							// A10 high closes all banks
							bus.cmd  <= sdram_pkg::PRE;
							bus.addr <= 12'h400;
							closing  <= 1'b0;
							delay    <= `T_RP;
							if (row_end && en && !fifo_empty && !rfsh_pend) begin
								state <= sdram_pkg::ACTIVE;
							end else begin
								state <= sdram_pkg::RESTART;
							end
						end
					end
					sdram_pkg::WRITE_BOTTOM: begin
						// pop lands at the end of this cycle, head is still valid
						bus.dq  <= fifo_data[15:0];
						bus.dqm <= fifo_data[33:32];
						state   <= sdram_pkg::WRITE_TOP;
					end
					default: begin
						state <= sdram_pkg::IDLE;
					end
				endcase
			end

			// pulse is one cycle wide, only ours while enabled
			if (auto_rfrsh && en) begin
				rfsh_pend <= 1'b1;
			end
		end
	end

endmodule

// ==== src/refresh_timer.sv ====
`timescale 1ns/1ps
`include "sdram_macros.svh"

module refresh_timer (
	input  logic clk,
	input  logic rst,
	output logic auto_rfrsh
);

	logic [7:0] count;
	logic       expired;

	assign expired = (count == 8'd0);

	// free running, independent of traffic
	always_ff @(posedge clk) begin
		if (rst) begin
			count      <= `REFRESH_INTERVAL - 8'd1;
			auto_rfrsh <= 1'b0;
		end else begin
			// one cycle request, then reload
			auto_rfrsh <= expired;
			if (expired) begin
				count <= `REFRESH_INTERVAL - 8'd1;
			end else begin
				count <= count - 8'd1;
			end
		end
	end

endmodule

// ==== src/write_fifo.sv ====
`timescale 1ns/1ps
`include "sdram_macros.svh"

module write_fifo (
	input  logic        clk,
	input  logic        rst,
	input  logic [35:0] wdata,
	input  logic        wr,
	output logic        full,
	output logic [35:0] rdata,
	input  logic        rd,
	output logic        empty
);

	logic [35:0]          mem [`FIFO_DEPTH];
	logic [`FIFO_AW-1:0]  wr_ptr;
	logic [`FIFO_AW-1:0]  rd_ptr;
	logic [`FIFO_AW:0]    count;
	logic                 wr_ok;
	logic                 rd_ok;

	// requests that would overflow or underflow are dropped
	assign wr_ok = wr && !full;
	assign rd_ok = rd && !empty;

	assign full  = (count == `FIFO_DEPTH);
	assign empty = (count == '0);

	// head word visible while not empty
	assign rdata = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_ok) begin
			mem[wr_ptr] <= wdata;
		end
	end

	// pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_ok, rd_ok})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== src/sdram_bus_if.sv ====
`timescale 1ns/1ps

// command bus from the write engine to the pin stage
// one command per cycle, NOP when idle
interface sdram_bus_if;

	sdram_pkg::sdram_cmd_e cmd;
	logic [11:0]           addr;
	logic [1:0]            bank;
	logic [15:0]           dq;
	logic [1:0]            dqm;

	modport ctl (
		output cmd,
		output addr,
		output bank,
		output dq,
		output dqm
	);

	modport phy (
		input cmd,
		input addr,
		input bank,
		input dq,
		input dqm
	);

endinterface

// ==== src/sdram_pkg.sv ====
package sdram_pkg;

	// SDRAM command as issued by the write engine
	typedef enum logic [2:0] {
		NOP   = 3'd0,
		ACT   = 3'd1,
		WRITE = 3'd2,
		PRE   = 3'd3,
		AR    = 3'd4
	} sdram_cmd_e;

	// write engine FSM
	typedef enum logic [2:0] {
		// row closed, nothing to do
		IDLE         = 3'd0,
		// open the row
		ACTIVE       = 3'd1,
		// first WRITE after ACT
		WRITE_CMD    = 3'd2,
		// top beat, or close the row
		WRITE_TOP    = 3'd3,
		// bottom beat
		WRITE_BOTTOM = 3'd4,
		// row closed, waiting for the host
		FIFO_WAIT    = 3'd5,
		// row closed after refresh or disable
		RESTART      = 3'd6
	} write_state_e;

endpackage

// ==== src/sdram_macros.svh ====
`ifndef SDRAM_MACROS_SVH
`define SDRAM_MACROS_SVH

// idle cycles after ACT before the first WRITE
`define T_RCD 4'd3

// idle cycles after PRE before the next ACT
`define T_RP 4'd3

// idle cycles after AUTO REFRESH
`define T_RFC 4'd7

// write recovery, last data beat to PRE
`define T_CAS 4'd2

// cycles between two refresh requests
`define REFRESH_INTERVAL 8'd200

// write FIFO, depth must stay 2**FIFO_AW
`define FIFO_AW 4
`define FIFO_DEPTH 5'd16

`endif
